// ==== bus_decoder.sv ====
/* Address decoder. Turns the host address into drive and rotation write
   strobes plus the channel index and byte offset used by the read mux. */
`timescale 1ns/1ps
`default_nettype none

module bus_decoder #(
    parameter int NUM_DRIVE = 4,
    parameter int NUM_ROT   = 4
) (
    input  motor_regs_pkg::addr_t  address,
    input  logic                   write_en,
    output logic [NUM_DRIVE-1:0]   drive_wr,
    output logic [NUM_ROT-1:0]     rot_wr,
    output logic                   hit_drive,
    output logic                   hit_rot,
    output logic [2:0]             chan,
    output logic [2:0]             reg_offset
);
    import motor_regs_pkg::*;

    logic bcast_wr;     // Write to either drive broadcast address
    logic rot_wr_off;   // Offset is a writable rotation byte

    // True when addr sits inside [base, base + stride)
    function automatic logic in_block(input addr_t addr, input int base, input int stride);
        return (int'(addr) >= base) && (int'(addr) < base + stride);
    endfunction

    always_comb begin
        hit_drive  = 1'b0;
        hit_rot    = 1'b0;
        chan       = '0;
        reg_offset = '0;
        for (int i = 0; i < MAX_DRIVE; i++) begin
            if (i < NUM_DRIVE && in_block(address, DRIVE_BASE + i * DRIVE_STRIDE, DRIVE_STRIDE)) begin
                hit_drive  = 1'b1;
                chan       = 3'(i);
                reg_offset = 3'(int'(address) - (DRIVE_BASE + i * DRIVE_STRIDE));
            end
        end
        for (int i = 0; i < MAX_ROT; i++) begin
            if (i < NUM_ROT && in_block(address, ROT_BASE + i * ROT_STRIDE, ROT_STRIDE)) begin
                hit_rot    = 1'b1;
                chan       = 3'(i);
                reg_offset = 3'(int'(address) - (ROT_BASE + i * ROT_STRIDE));
            end
        end
    end

    assign bcast_wr   = write_en && (address == ADDR_BCAST_ALL || address == ADDR_BCAST_DRIVE);
    assign rot_wr_off = (reg_offset == ROT_CTRL) || (reg_offset == ROT_TARGET) ||
                        (reg_offset == ROT_ANGLE_HI);   // Offsets 2, 4..6 are read only

    always_comb begin
        for (int n = 0; n < NUM_DRIVE; n++) begin
            // Control byte only, status is never written
            drive_wr[n] = bcast_wr || (write_en && hit_drive && chan == 3'(n) && reg_offset == '0);
        end
        for (int n = 0; n < NUM_ROT; n++) begin
            rot_wr[n] = write_en && hit_rot && rot_wr_off && chan == 3'(n);
        end
    end

    // Drive and rotation regions never overlap
    always_comb begin
        assert final (!(hit_drive && hit_rot) && !((|drive_wr) && (|rot_wr)))
            else $error("bus_decoder: drive and rotation decode overlap at %h", address);
    end

endmodule

`default_nettype wire

// ==== drive_channel.sv ====
/* One drive motor channel. Holds the writable control byte and samples
   the live status byte every clock. */
`timescale 1ns/1ps
`default_nettype none

module drive_channel (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic                                wr,
    input  motor_regs_pkg::byte_t               wr_data,
    input  logic                                fault,
    input  logic                                startup_fail,
    input  logic [motor_regs_pkg::TEMP_W-1:0]   adc_temp,
    output logic                                brake,
    output logic                                sd_enable,
    output logic                                direction,
    output logic [motor_regs_pkg::PWM_W-1:0]    pwm,
    output motor_regs_pkg::byte_t               ctrl_byte,
    output motor_regs_pkg::byte_t               status_byte
);
    import motor_regs_pkg::*;

    byte_t ctrl_q;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ctrl_q <= '0;
        end else if (wr) begin
            ctrl_q <= wr_data;   // Direct or broadcast write
        end
    end

    // Status resampled every edge
    always_ff @(posedge clock) begin
        status_byte <= {fault, startup_fail, adc_temp};
    end

    // Control byte fields
    assign brake     = ctrl_q[7];
    assign sd_enable = ctrl_q[6];
    assign direction = ctrl_q[5];
    assign pwm       = ctrl_q[PWM_W-1:0];
    assign ctrl_byte = ctrl_q;

    // Outputs come up idle after reset
    a_ctrl_reset: assert property (@(posedge clock) !rst_n |=> ctrl_byte == '0)
        else $error("drive_channel: control byte not cleared by reset");

endmodule

`default_nettype wire

// ==== motor_reg_top.sv ====
/* Top of the motor register block. Places the address decoder, the drive
   and rotation channel arrays and the read mux behind the host bus. */
`timescale 1ns/1ps
`default_nettype none

module motor_reg_top #(
    parameter int NUM_DRIVE = 4,   // 1..4
    parameter int NUM_ROT   = 4    // 1..5
) (
    input  logic                                                clock,
    input  logic                                                rst_n,
    input  logic                                                read_en,
    input  logic                                                write_en,
    input  motor_regs_pkg::addr_t                               address,
    input  motor_regs_pkg::byte_t                               wr_data,
    output motor_regs_pkg::byte_t                               rd_data,
    input  logic [NUM_DRIVE-1:0]                                fault,
    input  logic [NUM_DRIVE-1:0][motor_regs_pkg::TEMP_W-1:0]    adc_temp,
    input  logic [7:0]                                          startup_fail,
    output logic [NUM_DRIVE-1:0]                                brake,
    output logic [NUM_DRIVE-1:0]                                sd_enable,
    output logic [NUM_DRIVE-1:0]                                direction,
    output logic [NUM_DRIVE-1:0][motor_regs_pkg::PWM_W-1:0]     pwm,
    output logic [NUM_ROT-1:0]                                  calib_en,
    output logic [NUM_ROT-1:0]                                  sr_enable,
    output logic [NUM_ROT-1:0]                                  stall_chk_en,
    output motor_regs_pkg::angle_t [NUM_ROT-1:0]                target_angle,
    input  motor_regs_pkg::angle_t [NUM_ROT-1:0]                current_angle,
    output logic [NUM_ROT-1:0]                                  update_angle,
    output logic [NUM_ROT-1:0]                                  abort_angle,
    input  logic [NUM_ROT-1:0]                                  angle_done
);
    import motor_regs_pkg::*;

    logic [NUM_DRIVE-1:0]   drive_wr;
    logic [NUM_ROT-1:0]     rot_wr;
    logic                   hit_drive;
    logic                   hit_rot;
    logic [2:0]             chan;
    logic [2:0]             reg_offset;

    // Channel readback bytes
    byte_t [NUM_DRIVE-1:0]  drive_ctrl;
    byte_t [NUM_DRIVE-1:0]  drive_status;
    byte_t [NUM_ROT-1:0]    rot_ctrl;
    byte_t [NUM_ROT-1:0]    rot_target;
    byte_t [NUM_ROT-1:0]    rot_angle_lo;
    byte_t [NUM_ROT-1:0]    rot_angle_hi;

    bus_decoder #(
        .NUM_DRIVE (NUM_DRIVE),
        .NUM_ROT   (NUM_ROT)
    ) i_bus_decoder (
        .address    (address),
        .write_en   (write_en),
        .drive_wr   (drive_wr),
        .rot_wr     (rot_wr),
        .hit_drive  (hit_drive),
        .hit_rot    (hit_rot),
        .chan       (chan),
        .reg_offset (reg_offset)
    );

    for (genvar n = 0; n < NUM_DRIVE; n++) begin : g_drive
        drive_channel i_drive_channel (
            .clock        (clock),
            .rst_n        (rst_n),
            .wr           (drive_wr[n]),
            .wr_data      (wr_data),
            .fault        (fault[n]),
            .startup_fail (startup_fail[n]),   // One fail bit per drive
            .adc_temp     (adc_temp[n]),
            .brake        (brake[n]),
            .sd_enable    (sd_enable[n]),
            .direction    (direction[n]),
            .pwm          (pwm[n]),
            .ctrl_byte    (drive_ctrl[n]),
            .status_byte  (drive_status[n])
        );
    end

    for (genvar n = 0; n < NUM_ROT; n++) begin : g_rot
        rotation_channel i_rotation_channel (
            .clock         (clock),
            .rst_n         (rst_n),
            .wr            (rot_wr[n]),
            .reg_offset    (reg_offset),
            .wr_data       (wr_data),
            .startup_fail  (startup_fail[4]),   // Shared by all rotation channels
            .current_angle (current_angle[n]),
            .angle_done    (angle_done[n]),
            .calib_en      (calib_en[n]),
            .sr_enable     (sr_enable[n]),
            .stall_chk_en  (stall_chk_en[n]),
            .target_angle  (target_angle[n]),
            .update_angle  (update_angle[n]),
            .abort_angle   (abort_angle[n]),
            .ctrl_byte     (rot_ctrl[n]),
            .target_byte   (rot_target[n]),
            .angle_lo_byte (rot_angle_lo[n]),
            .angle_hi_byte (rot_angle_hi[n])
        );
    end

    readback_mux #(
        .NUM_DRIVE (NUM_DRIVE),
        .NUM_ROT   (NUM_ROT)
    ) i_readback_mux (
        .clock        (clock),
        .rst_n        (rst_n),
        .read_en      (read_en),
        .hit_drive    (hit_drive),
        .hit_rot      (hit_rot),
        .chan         (chan),
        .reg_offset   (reg_offset),
        .drive_ctrl   (drive_ctrl),
        .drive_status (drive_status),
        .rot_ctrl     (rot_ctrl),
        .rot_target   (rot_target),
        .rot_angle_lo (rot_angle_lo),
        .rot_angle_hi (rot_angle_hi),
        .rd_data      (rd_data)
    );

endmodule

`default_nettype wire

// ==== motor_regs_pkg.sv ====
/* Shared widths, byte and angle types, address map and bit positions
   for the swerve motor register block. Modules import it in their body. */
`default_nettype none

package motor_regs_pkg;

    // Bus and field widths
    localparam int ADDR_W  = 6;    // 64-byte register space
    localparam int DATA_W  = 8;
    localparam int ANGLE_W = 12;   // Rotation encoder resolution
    localparam int PWM_W   = 5;
    localparam int TEMP_W  = 6;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  byte_t;
    typedef logic [ANGLE_W-1:0] angle_t;

    // Broadcast addresses, both reach every drive control byte
    localparam addr_t ADDR_BCAST_ALL   = 6'h01;
    localparam addr_t ADDR_BCAST_DRIVE = 6'h03;

    // Drive blocks: control then status
    localparam int DRIVE_BASE   = 'h04;
    localparam int DRIVE_STRIDE = 2;

    // Rotation blocks, seven bytes each
    localparam int ROT_BASE   = 'h0C;
    localparam int ROT_STRIDE = 7;

    // Offsets inside a rotation block
    localparam int ROT_CTRL     = 0;
    localparam int ROT_TARGET   = 1;
    localparam int ROT_ANGLE_LO = 2;
    localparam int ROT_ANGLE_HI = 3;   // Also the command byte on write

    // Command byte bits
    localparam int CMD_ABORT_BIT  = 4;
    localparam int CMD_UPDATE_BIT = 5;
    localparam int CMD_SNAP_BIT   = 6;

    // Rotation control bit replaced by startup_fail on write
    localparam int CTRL_FAIL_BIT = 4;

    // Largest channel counts the address map can hold
    localparam int MAX_DRIVE = 4;
    localparam int MAX_ROT   = 5;

endpackage

`default_nettype wire

// ==== readback_mux.sv ====
/* Read path. Picks the addressed byte from the channel outputs and
   registers it onto rd_data, one cycle after the read is sampled. */
`timescale 1ns/1ps
`default_nettype none

module readback_mux #(
    parameter int NUM_DRIVE = 4,
    parameter int NUM_ROT   = 4
) (
    input  logic                                    clock,
    input  logic                                    rst_n,
    input  logic                                    read_en,
    input  logic                                    hit_drive,
    input  logic                                    hit_rot,
    input  logic [2:0]                              chan,
    input  logic [2:0]                              reg_offset,
    input  motor_regs_pkg::byte_t [NUM_DRIVE-1:0]   drive_ctrl,
    input  motor_regs_pkg::byte_t [NUM_DRIVE-1:0]   drive_status,
    input  motor_regs_pkg::byte_t [NUM_ROT-1:0]     rot_ctrl,
    input  motor_regs_pkg::byte_t [NUM_ROT-1:0]     rot_target,
    input  motor_regs_pkg::byte_t [NUM_ROT-1:0]     rot_angle_lo,
    input  motor_regs_pkg::byte_t [NUM_ROT-1:0]     rot_angle_hi,
    output motor_regs_pkg::byte_t                   rd_data
);
    import motor_regs_pkg::*;

    byte_t sel;   // Byte at the current address

    always_comb begin
        sel = '0;   // Unmapped addresses read zero
        if (hit_drive) begin
            sel = reg_offset[0] ? drive_status[chan] : drive_ctrl[chan];
        end else if (hit_rot) begin
            case (reg_offset)
                ROT_CTRL:     sel = rot_ctrl[chan];
                ROT_TARGET:   sel = rot_target[chan];
                ROT_ANGLE_LO: sel = rot_angle_lo[chan];
                ROT_ANGLE_HI: sel = rot_angle_hi[chan];
                default:      sel = '0;   // Offsets 4..6 unused
            endcase
        end
    end

    // Holds until the next read
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (read_en) begin
            rd_data <= sel;
        end
    end

    // Decoder only flags channels that exist
    a_chan_range: assert property (@(posedge clock) disable iff (!rst_n)
        (hit_drive |-> int'(chan) < NUM_DRIVE) and (hit_rot |-> int'(chan) < NUM_ROT))
        else $error("readback_mux: channel %0d out of range", chan);

endmodule

`default_nettype wire

// ==== rotation_channel.sv ====
/* One rotation motor channel. Control and target bytes, an angle snapshot
   and the one-cycle abort and update pulses fired from the command byte. */
`timescale 1ns/1ps
`default_nettype none

module rotation_channel (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    wr,
    input  logic [2:0]              reg_offset,
    input  motor_regs_pkg::byte_t   wr_data,
    input  logic                    startup_fail,
    input  motor_regs_pkg::angle_t  current_angle,
    input  logic                    angle_done,
    output logic                    calib_en,
    output logic                    sr_enable,
    output logic                    stall_chk_en,
    output motor_regs_pkg::angle_t  target_angle,
    output logic                    update_angle,
    output logic                    abort_angle,
    output motor_regs_pkg::byte_t   ctrl_byte,
    output motor_regs_pkg::byte_t   target_byte,
    output motor_regs_pkg::byte_t   angle_lo_byte,
    output motor_regs_pkg::byte_t   angle_hi_byte
);
    import motor_regs_pkg::*;

    byte_t  ctrl_q;
    byte_t  ctrl_d;
    byte_t  target_q;
    angle_t snap_q;      // Angle frozen at the last snap command
    logic   done_q;
    logic   ctrl_wr;
    logic   target_wr;
    logic   cmd_wr;

    assign ctrl_wr   = wr && (reg_offset == ROT_CTRL);
    assign target_wr = wr && (reg_offset == ROT_TARGET);
    assign cmd_wr    = wr && (reg_offset == ROT_ANGLE_HI);

    // Fail bit comes from the pin, not the host
    always_comb begin
        ctrl_d                = wr_data;
        ctrl_d[CTRL_FAIL_BIT] = startup_fail;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ctrl_q       <= '0;
            target_q     <= '0;
            snap_q       <= '0;
            abort_angle  <= 1'b0;
            update_angle <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                ctrl_q <= ctrl_d;
            end
            if (target_wr) begin
                target_q <= wr_data;
            end
            // Pulses last one cycle, repeat on back-to-back commands
            abort_angle  <= cmd_wr && wr_data[CMD_ABORT_BIT];
            update_angle <= cmd_wr && wr_data[CMD_UPDATE_BIT];
            // Freeze both angle bytes so lo and hi reads agree
            if (cmd_wr && wr_data[CMD_SNAP_BIT]) begin
                snap_q <= current_angle;
            end
        end
    end

    always_ff @(posedge clock) begin
        done_q <= angle_done;   // Live flag, sampled every edge
    end

    // Control byte fields
    assign calib_en     = ctrl_q[7];
    assign sr_enable    = ctrl_q[6];
    assign stall_chk_en = ctrl_q[5];
    assign target_angle = {ctrl_q[3:0], target_q};   // Upper nibble lives in control

    // Readback bytes
    assign ctrl_byte     = ctrl_q;
    assign target_byte   = target_q;
    assign angle_lo_byte = snap_q[7:0];
    assign angle_hi_byte = {done_q, 3'b000, snap_q[ANGLE_W-1:8]};

    // Every update pulse traces back to a command write one edge earlier
    a_update_cause: assert property (@(posedge clock) disable iff (!rst_n)
        update_angle |-> $past(cmd_wr && wr_data[CMD_UPDATE_BIT]))
        else $error("rotation_channel: update_angle without command write");

endmodule

`default_nettype wire

// ==== tb_motor_regs.sv ====
/* Self-checking testbench for motor_reg_top. Keeps a register model,
   predicts every read with a reference function and checks rd_data and outputs. */
`timescale 1ns/1ps
`default_nettype none

module tb_motor_regs;
    import motor_regs_pkg::*;

    localparam int NUM_DRIVE      = 4;
    localparam int NUM_ROT        = 4;
    localparam int TIMEOUT_CYCLES = 4000;   // Well above the few hundred cycles needed

    logic                               clock = 1'b0;
    logic                               rst_n;
    logic                               read_en;
    logic                               write_en;
    addr_t                              address;
    byte_t                              wr_data;
    byte_t                              rd_data;
    logic [NUM_DRIVE-1:0]               fault;
    logic [NUM_DRIVE-1:0][TEMP_W-1:0]   adc_temp;
    logic [7:0]                         startup_fail;
    logic [NUM_DRIVE-1:0]               brake;
    logic [NUM_DRIVE-1:0]               sd_enable;
    logic [NUM_DRIVE-1:0]               direction;
    logic [NUM_DRIVE-1:0][PWM_W-1:0]    pwm;
    logic [NUM_ROT-1:0]                 calib_en;
    logic [NUM_ROT-1:0]                 sr_enable;
    logic [NUM_ROT-1:0]                 stall_chk_en;
    angle_t [NUM_ROT-1:0]               target_angle;
    angle_t [NUM_ROT-1:0]               current_angle;
    logic [NUM_ROT-1:0]                 update_angle;
    logic [NUM_ROT-1:0]                 abort_angle;
    logic [NUM_ROT-1:0]                 angle_done;

    // Register model
    byte_t  drv_ctrl_m [NUM_DRIVE];
    byte_t  rot_ctrl_m [NUM_ROT];
    byte_t  rot_tgt_m  [NUM_ROT];
    angle_t snap_m     [NUM_ROT];

    byte_t       exp_q[$];      // Expected bytes of reads in flight
    addr_t       addr_q[$];
    logic        read_seen = 1'b0;
    logic [31:0] lfsr_state = 32'hafd3;
    int          cycle_count = 0;
    int          checks = 0;
    int          errors = 0;
    int          errs_at_start;

    motor_reg_top i_motor_reg_top (
        .clock (clock), .rst_n (rst_n), .read_en (read_en), .write_en (write_en),
        .address (address), .wr_data (wr_data), .rd_data (rd_data),
        .fault (fault), .adc_temp (adc_temp), .startup_fail (startup_fail),
        .brake (brake), .sd_enable (sd_enable), .direction (direction), .pwm (pwm),
        .calib_en (calib_en), .sr_enable (sr_enable), .stall_chk_en (stall_chk_en),
        .target_angle (target_angle), .current_angle (current_angle),
        .update_angle (update_angle), .abort_angle (abort_angle), .angle_done (angle_done)
    );

    always #50 clock = ~clock;   // 100 ns period

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r          = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return r;
    endfunction

    // Byte a read of address a should return, from model and held inputs
    function automatic byte_t expected_read(input addr_t a);
        int ai;
        int n;
        int off;
        ai = int'(a);
        if (ai >= DRIVE_BASE && ai < DRIVE_BASE + NUM_DRIVE * DRIVE_STRIDE) begin
            n   = (ai - DRIVE_BASE) / DRIVE_STRIDE;
            off = (ai - DRIVE_BASE) % DRIVE_STRIDE;
            return (off == 0) ? drv_ctrl_m[n] : {fault[n], startup_fail[n], adc_temp[n]};
        end
        if (ai >= ROT_BASE && ai < ROT_BASE + NUM_ROT * ROT_STRIDE) begin
            n   = (ai - ROT_BASE) / ROT_STRIDE;
            off = (ai - ROT_BASE) % ROT_STRIDE;
            case (off)
                ROT_CTRL:     return rot_ctrl_m[n];
                ROT_TARGET:   return rot_tgt_m[n];
                ROT_ANGLE_LO: return snap_m[n][7:0];
                ROT_ANGLE_HI: return {angle_done[n], 3'b000, snap_m[n][11:8]};
                default:      return '0;   // Offsets 4..6
            endcase
        end
        return '0;   // Reserved or unmapped
    endfunction

    // Apply one host write to the model
    function automatic void model_write(input addr_t a, input byte_t d);
        int ai;
        int n;
        int off;
        ai = int'(a);
        if (a == ADDR_BCAST_ALL || a == ADDR_BCAST_DRIVE) begin
            foreach (drv_ctrl_m[i]) drv_ctrl_m[i] = d;
        end else if (ai >= DRIVE_BASE && ai < DRIVE_BASE + NUM_DRIVE * DRIVE_STRIDE) begin
            n = (ai - DRIVE_BASE) / DRIVE_STRIDE;
            if ((ai - DRIVE_BASE) % DRIVE_STRIDE == 0) drv_ctrl_m[n] = d;
        end else if (ai >= ROT_BASE && ai < ROT_BASE + NUM_ROT * ROT_STRIDE) begin
            n   = (ai - ROT_BASE) / ROT_STRIDE;
            off = (ai - ROT_BASE) % ROT_STRIDE;
            if (off == ROT_CTRL) rot_ctrl_m[n] = {d[7:5], startup_fail[4], d[3:0]};
            if (off == ROT_TARGET) rot_tgt_m[n] = d;
            if (off == ROT_ANGLE_HI && d[CMD_SNAP_BIT]) snap_m[n] = current_angle[n];
        end
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %0h expected %0h", name, got, exp);
        end
    endtask

    // All control outputs against the model
    task automatic check_outputs();
        logic [NUM_DRIVE-1:0]            e_brake;
        logic [NUM_DRIVE-1:0]            e_en;
        logic [NUM_DRIVE-1:0]            e_dir;
        logic [NUM_DRIVE-1:0][PWM_W-1:0] e_pwm;
        logic [NUM_ROT-1:0]              e_cal;
        logic [NUM_ROT-1:0]              e_sr;
        logic [NUM_ROT-1:0]              e_stall;
        angle_t [NUM_ROT-1:0]            e_tgt;
        for (int n = 0; n < NUM_DRIVE; n++) begin
            {e_brake[n], e_en[n], e_dir[n], e_pwm[n]} = drv_ctrl_m[n];
        end
        for (int n = 0; n < NUM_ROT; n++) begin
            {e_cal[n], e_sr[n], e_stall[n]} = rot_ctrl_m[n][7:5];
            e_tgt[n] = {rot_ctrl_m[n][3:0], rot_tgt_m[n]};
        end
        check_value("brake", brake, e_brake);
        check_value("sd_enable", sd_enable, e_en);
        check_value("direction", direction, e_dir);
        check_value("pwm", pwm, e_pwm);
        check_value("calib_en", calib_en, e_cal);
        check_value("sr_enable", sr_enable, e_sr);
        check_value("stall_chk_en", stall_chk_en, e_stall);
        check_value("target_angle", target_angle, e_tgt);
    endtask

    task automatic check_pulses(input logic [NUM_ROT-1:0] e_upd, input logic [NUM_ROT-1:0] e_abt);
        check_value("update_angle", update_angle, e_upd);
        check_value("abort_angle", abort_angle, e_abt);
    endtask

    // Bus tasks start and end on a falling edge
    task automatic write_reg(input int a, input byte_t d);
        write_en = 1'b1;
        address  = addr_t'(a);
        wr_data  = d;
        model_write(addr_t'(a), d);   // Model now matches the state after the edge
        @(negedge clock);
        write_en = 1'b0;
    endtask

    task automatic read_reg(input int a);
        read_en = 1'b1;
        address = addr_t'(a);
        exp_q.push_back(expected_read(addr_t'(a)));
        addr_q.push_back(addr_t'(a));
        @(negedge clock);
        read_en = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clock);
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, errors - errs_at_start);
        errs_at_start = errors;
    endtask

    // Read sampled on the last rising edge
    always @(posedge clock) read_seen <= read_en;

    // Compare rd_data once it has settled after the read edge
    always @(negedge clock) begin
        if (read_seen) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Read completed with no expected value queued");
            end else begin
                check_value($sformatf("rd_data at address %0h", addr_q.pop_front()),
                            rd_data, exp_q.pop_front());
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        rst_n = 1'b0;
        read_en = 1'b0;
        write_en = 1'b0;
        address = '0;
        wr_data = '0;
        fault = '0;
        adc_temp = '0;
        startup_fail = '0;
        current_angle = '0;
        angle_done = '0;
        foreach (drv_ctrl_m[i]) drv_ctrl_m[i] = '0;
        foreach (rot_ctrl_m[i]) rot_ctrl_m[i] = '0;
        foreach (rot_tgt_m[i]) rot_tgt_m[i] = '0;
        foreach (snap_m[i]) snap_m[i] = '0;
        errs_at_start = 0;
        idle(10);
        rst_n = 1'b1;

        // Test 1: reset state
        check_outputs();
        check_pulses('0, '0);
        check_value("rd_data", rd_data, 8'h00);
        for (int a = 0; a < 64; a++) read_reg(a);
        idle(1);
        end_test("reset");

        // Test 2: drive control writes, one channel at a time
        for (int n = 0; n < NUM_DRIVE; n++) begin
            repeat (4) begin
                write_reg(DRIVE_BASE + n * DRIVE_STRIDE, byte_t'(rand_bits(8)));
                check_outputs();
                read_reg(DRIVE_BASE + n * DRIVE_STRIDE);
            end
        end
        idle(1);
        end_test("drive_writes");

        // Test 3: broadcast and reserved addresses, with rotation targets loaded
        for (int n = 0; n < NUM_ROT; n++) write_reg(ROT_BASE + n * ROT_STRIDE + ROT_TARGET,
                                                    byte_t'(rand_bits(8)));
        for (int k = 0; k < 4; k++) begin
            write_reg(k, byte_t'(rand_bits(8)));   // 0x00 and 0x02 must change nothing
            check_outputs();
            for (int n = 0; n < NUM_DRIVE; n++) read_reg(DRIVE_BASE + n * DRIVE_STRIDE);
            for (int n = 0; n < NUM_ROT; n++) begin
                read_reg(ROT_BASE + n * ROT_STRIDE + ROT_CTRL);
                read_reg(ROT_BASE + n * ROT_STRIDE + ROT_TARGET);
            end
        end
        idle(1);
        end_test("broadcast");

        // Test 4: live drive status, held two cycles before reading
        repeat (4) begin
            fault = rand_bits(NUM_DRIVE);
            for (int n = 0; n < NUM_DRIVE; n++) adc_temp[n] = rand_bits(TEMP_W);
            startup_fail = rand_bits(8);
            idle(2);
            for (int n = 0; n < NUM_DRIVE; n++) read_reg(DRIVE_BASE + n * DRIVE_STRIDE + 1);
        end
        idle(1);
        end_test("status");

        // Test 5: rotation control and target, fail bit captured at the write
        for (int n = 0; n < NUM_ROT; n++) begin
            repeat (3) begin
                startup_fail = rand_bits(8);
                write_reg(ROT_BASE + n * ROT_STRIDE + ROT_CTRL, byte_t'(rand_bits(8)));
                write_reg(ROT_BASE + n * ROT_STRIDE + ROT_TARGET, byte_t'(rand_bits(8)));
                check_outputs();
                startup_fail[4] = ~startup_fail[4];   // Later change must not show
                for (int k = 0; k < ROT_STRIDE; k++) read_reg(ROT_BASE + n * ROT_STRIDE + k);
            end
        end
        idle(1);
        end_test("rotation_ctrl");

        // Test 6: snapshot, angle_done and command pulses
        for (int n = 0; n < NUM_ROT; n++) begin
            current_angle[n] = rand_bits(ANGLE_W);
            angle_done[n]    = rand_bits(1);
            write_reg(ROT_BASE + n * ROT_STRIDE + ROT_ANGLE_HI, 8'h40);
            check_pulses('0, '0);
            current_angle[n] = rand_bits(ANGLE_W);   // Snapshot stays frozen
            idle(2);
            read_reg(ROT_BASE + n * ROT_STRIDE + ROT_ANGLE_LO);
            read_reg(ROT_BASE + n * ROT_STRIDE + ROT_ANGLE_HI);
            write_reg(ROT_BASE + n * ROT_STRIDE + ROT_ANGLE_HI, 8'h20);
            check_pulses(NUM_ROT'(1) << n, '0);
            idle(1);
            check_pulses('0, '0);
            write_reg(ROT_BASE + n * ROT_STRIDE + ROT_ANGLE_HI, 8'h10);
            check_pulses('0, NUM_ROT'(1) << n);
            // Back-to-back commands give back-to-back pulses
            write_reg(ROT_BASE + n * ROT_STRIDE + ROT_ANGLE_HI, 8'h30);
            check_pulses(NUM_ROT'(1) << n, NUM_ROT'(1) << n);
            write_reg(ROT_BASE + n * ROT_STRIDE + ROT_ANGLE_HI, 8'h30);
            check_pulses(NUM_ROT'(1) << n, NUM_ROT'(1) << n);
            idle(1);
            check_pulses('0, '0);
            check_outputs();
            // Done flag is live, snapshot untouched by commands without snap
            angle_done[n] = ~angle_done[n];
            idle(2);
            read_reg(ROT_BASE + n * ROT_STRIDE + ROT_ANGLE_LO);
            read_reg(ROT_BASE + n * ROT_STRIDE + ROT_ANGLE_HI);
        end
        idle(2);
        end_test("commands");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
motor_regs_pkg.sv
bus_decoder.sv
drive_channel.sv
rotation_channel.sv
readback_mux.sv
motor_reg_top.sv
tb_motor_regs.sv
